/* project.f */
src/wb_pkg.sv
src/cache_pkg.sv
src/cache_ctrl_fsm.sv
src/lru_age_table.sv
src/tag_store.sv
src/data_store.sv
src/main_ram.sv
src/cache_top.sv
test/clk_gen.sv
test/cache_assert.sv
test/cache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
	-f project.f -o sim_cache

# Keep running past assertion errors so the testbench prints its summary
out=$(./obj_dir/sim_cache +verilator+error+limit+1000 || true)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1

/* src/cache_ctrl_fsm.sv */
`timescale 1ns/1ps

module cache_ctrl_fsm (
	input  logic                clk,
	input  logic                rst_n,
	input  wb_pkg::wb_req_t     cpu_req,	// Processor side slave port
	output wb_pkg::wb_rsp_t     cpu_rsp,
	output logic                hit,		// Acked access was a hit
	input  cache_pkg::lookup_t  lookup,		// From tag_store
	input  cache_pkg::way_idx_t lru_way,	// From lru_age_table
	output logic                tag_we,
	output cache_pkg::way_idx_t tag_way,
	output logic                tag_dirty,
	input  logic [7:0]          rd_byte,	// Byte of data_way
	output logic                data_we,
	output cache_pkg::way_idx_t data_way,
	output logic [7:0]          data_byte,
	output logic                touch,
	output cache_pkg::way_idx_t touch_way,
	output wb_pkg::wb_req_t     ram_req,	// Master port towards main_ram
	input  wb_pkg::wb_rsp_t     ram_rsp
);

	cache_pkg::ctrl_state_t state, state_nxt;
	wb_pkg::wb_op_t         req_op;		// Registered processor request
	logic [7:0]             req_adr;
	logic [7:0]             req_dat;
	cache_pkg::way_idx_t    acc_way;	// Hit way or victim, chosen once in lookup
	logic                   hit_r;
	logic [7:0]             rsp_dat;	// Byte returned with ack
	logic                   access;		// Access performed this cycle

	assign access = (state == cache_pkg::S_HIT) || (state == cache_pkg::S_REPLAY);

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cache_pkg::S_IDLE;
			hit_r <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == cache_pkg::S_LOOKUP)
				hit_r <= lookup.hit;
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (state == cache_pkg::S_IDLE) begin
			req_op  <= cpu_req.op;
			req_adr <= cpu_req.adr;
			req_dat <= cpu_req.dat;
		end
		if (state == cache_pkg::S_LOOKUP)
			acc_way <= lookup.hit ? lookup.way : lru_way;	// Victim on a miss
		if (access)
			rsp_dat <= (req_op == wb_pkg::WB_WRITE) ? req_dat : rd_byte;
	end

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			cache_pkg::S_IDLE:
				if (cpu_req.cyc && cpu_req.stb)
					state_nxt = cache_pkg::S_LOOKUP;
			cache_pkg::S_LOOKUP:
				if (lookup.hit)
					state_nxt = cache_pkg::S_HIT;
				else if (lookup.victim_dirty)
					state_nxt = cache_pkg::S_EVICT;	// Write back first
				else
					state_nxt = cache_pkg::S_FILL;
			cache_pkg::S_EVICT:
				if (ram_rsp.ack)
					state_nxt = cache_pkg::S_FILL;
			cache_pkg::S_FILL:
				if (ram_rsp.ack)
					state_nxt = cache_pkg::S_REPLAY;
			cache_pkg::S_HIT,
			cache_pkg::S_REPLAY:
				state_nxt = cache_pkg::S_ACK;
			cache_pkg::S_ACK:
				state_nxt = cache_pkg::S_IDLE;
			default:
				state_nxt = cache_pkg::S_IDLE;
		endcase
	end

	////////////////////////////////////////
	// Store, age table and RAM controls
	////////////////////////////////////////

	assign tag_way   = acc_way;
	assign data_way  = acc_way;	// Also selects the read byte
	assign touch_way = acc_way;
	assign touch     = access;	// Once per acked access

	// Fill writes a clean line, a write access marks it dirty
	assign tag_we    = (state == cache_pkg::S_FILL && ram_rsp.ack) ||
	                   (access && req_op == wb_pkg::WB_WRITE);
	assign tag_dirty = (state != cache_pkg::S_FILL);
	assign data_we   = tag_we;
	assign data_byte = (state == cache_pkg::S_FILL) ? ram_rsp.dat : req_dat;

	always_comb begin
		ram_req = '0;
		if (state == cache_pkg::S_EVICT) begin
			ram_req.cyc = 1'b1;
			ram_req.stb = 1'b1;
			ram_req.op  = wb_pkg::WB_WRITE;
			ram_req.adr = lookup.victim_tag;	// Victim tag is its address
			ram_req.dat = rd_byte;
		end else if (state == cache_pkg::S_FILL) begin
			ram_req.cyc = 1'b1;
			ram_req.stb = 1'b1;
			ram_req.op  = wb_pkg::WB_READ;
			ram_req.adr = req_adr;
		end
	end

	// Processor response
	assign cpu_rsp.ack = (state == cache_pkg::S_ACK);
	assign cpu_rsp.dat = rsp_dat;
	assign hit         = (state == cache_pkg::S_ACK) && hit_r;

endmodule

/* src/cache_pkg.sv */
// Cache side types shared by the controller and the tag store
package cache_pkg;

	////////////////////////////////////////
	// Controller states
	////////////////////////////////////////

	typedef enum logic [2:0] {
		S_IDLE   = 3'd0,	// Waiting for a processor strobe
		S_LOOKUP = 3'd1,	// Tags compared, hit or miss decided
		S_HIT    = 3'd2,	// Access done on the matching way
		S_EVICT  = 3'd3,	// Dirty victim written back to RAM
		S_FILL   = 3'd4,	// Line read from RAM into the victim way
		S_REPLAY = 3'd5,	// Access done on the freshly filled way
		S_ACK    = 3'd6 	// One cycle of ack to the processor
	} ctrl_state_t;

	////////////////////////////////////////
	// Way index and lookup result
	////////////////////////////////////////

	// Sized for the default of four ways
	typedef logic [1:0] way_idx_t;

	// Result of the associative compare, plus victim info
	typedef struct packed {
		logic       hit;          // Some valid tag matched the address
		way_idx_t   way;          // Matching way, only meaningful on hit
		logic       victim_dirty; // LRU way holds modified data
		logic [7:0] victim_tag;   // Address the LRU way belongs to
	} lookup_t;

endpackage

/* src/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
	parameter int N_WAYS        = 4,
	parameter int RAM_INIT_SEED = 0
) (
	input  logic            clk,
	input  logic            rst_n,
	input  wb_pkg::wb_req_t cpu_req,
	output wb_pkg::wb_rsp_t cpu_rsp,
	output logic            hit
);

	cache_pkg::lookup_t  lookup;
	cache_pkg::way_idx_t lru_way;
	logic                tag_we;
	cache_pkg::way_idx_t tag_way;
	logic                tag_dirty;
	logic [7:0]          rd_byte;
	logic                data_we;
	cache_pkg::way_idx_t data_way;
	logic [7:0]          data_byte;
	logic                touch;
	cache_pkg::way_idx_t touch_way;
	wb_pkg::wb_req_t     ram_req;	// Controller as bus master
	wb_pkg::wb_rsp_t     ram_rsp;

	////////////////////////////////////////
	// Controller
	////////////////////////////////////////

	cache_ctrl_fsm u_ctrl (
		.clk, .rst_n, .cpu_req, .cpu_rsp, .hit, .lookup, .lru_way,
		.tag_we, .tag_way, .tag_dirty, .rd_byte,
		.data_we, .data_way, .data_byte, .touch, .touch_way,
		.ram_req, .ram_rsp
	);

	////////////////////////////////////////
	// Stores, ages and backing RAM
	////////////////////////////////////////

	// Processor holds adr stable until ack, so tags compare it directly
	tag_store #(.N_WAYS(N_WAYS)) u_tags (
		.clk, .rst_n, .adr(cpu_req.adr), .lru_way, .lookup,
		.tag_we, .tag_way, .tag_dirty
	);

	data_store #(.N_WAYS(N_WAYS)) u_data (
		.clk, .data_we, .data_way, .data_byte,
		.rd_way(data_way),	// Same way for read and write
		.rd_byte
	);

	lru_age_table #(.N_WAYS(N_WAYS)) u_lru (
		.clk, .rst_n, .touch, .touch_way, .lru_way
	);

	main_ram #(.RAM_INIT_SEED(RAM_INIT_SEED)) u_ram (
		.clk, .rst_n, .req(ram_req), .rsp(ram_rsp)
	);

endmodule

/* src/data_store.sv */
`timescale 1ns/1ps

module data_store #(
	parameter int N_WAYS = 4
) (
	input  logic                      clk,
	input  logic                      data_we,
	input  logic [$clog2(N_WAYS)-1:0] data_way,
	input  logic [7:0]                data_byte,
	input  logic [$clog2(N_WAYS)-1:0] rd_way,
	output logic [7:0]                rd_byte
);

	logic [7:0] line [N_WAYS];	// One byte per line

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (data_we)
			line[data_way] <= data_byte;
	end

	////////////////////////////////////////
	// Read mux
	////////////////////////////////////////

	// Asynchronous so write-back data is ready in the same cycle
	assign rd_byte = line[rd_way];

endmodule

/* src/lru_age_table.sv */
`timescale 1ns/1ps

module lru_age_table #(
	parameter int N_WAYS = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      touch,		// One pulse per access
	input  logic [$clog2(N_WAYS)-1:0] touch_way,
	output logic [$clog2(N_WAYS)-1:0] lru_way		// Way with age 0
);

	localparam int AW = $clog2(N_WAYS);

	logic [AW-1:0] age [N_WAYS];	// Highest age is most recently used
	logic [AW-1:0] touched_age;

	assign touched_age = age[touch_way];

	////////////////////////////////////////
	// Age update
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < N_WAYS; i++)
				age[i] <= AW'(i);	// Way 0 starts as LRU
		end else if (touch) begin
			for (int i = 0; i < N_WAYS; i++) begin
				if (touch_way == AW'(i))
					age[i] <= AW'(N_WAYS - 1);	// Becomes MRU
				else if (age[i] > touched_age)
					age[i] <= age[i] - 1'b1;	// Younger ways slide down
				// Older ways keep their age
			end
		end
	end

	////////////////////////////////////////
	// LRU select
	////////////////////////////////////////

	// Ages stay a permutation, so exactly one way is at zero
	always_comb begin
		lru_way = '0;
		for (int i = 0; i < N_WAYS; i++) begin
			if (age[i] == '0)
				lru_way = AW'(i);
		end
	end

endmodule

/* src/main_ram.sv */
`timescale 1ns/1ps

module main_ram #(
	parameter int RAM_INIT_SEED = 0
) (
	input  logic            clk,
	input  logic            rst_n,
	input  wb_pkg::wb_req_t req,	// Wishbone classic slave
	output wb_pkg::wb_rsp_t rsp
);

	logic [7:0] mem [256];
	logic       ack_r;
	logic [7:0] dat_r;
	logic       take;	// Strobe sampled, not yet acked

	assign take = req.cyc && req.stb && !ack_r;

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	// Ack one cycle after the strobe, never twice in a row
	always_ff @(posedge clk) begin
		if (!rst_n)
			ack_r <= 1'b0;
		else
			ack_r <= take;
	end

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= 8'(i * RAM_INIT_SEED);	// Zero with the default seed
		end else if (take && req.op == wb_pkg::WB_WRITE) begin
			mem[req.adr] <= req.dat;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			dat_r <= mem[req.adr];	// Shows up together with ack
	end

	assign rsp.ack = ack_r;
	assign rsp.dat = dat_r;

endmodule

/* src/tag_store.sv */
`timescale 1ns/1ps

module tag_store #(
	parameter int N_WAYS = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [7:0]                adr,			// Address being looked up
	input  logic [$clog2(N_WAYS)-1:0] lru_way,		// Victim candidate
	output cache_pkg::lookup_t        lookup,
	input  logic                      tag_we,		// Write tag = adr, set valid
	input  logic [$clog2(N_WAYS)-1:0] tag_way,
	input  logic                      tag_dirty
);

	logic [7:0]        tag [N_WAYS];
	logic [N_WAYS-1:0] valid;
	logic [N_WAYS-1:0] dirty;

	// Valid and dirty flags
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (tag_we) begin
			valid[tag_way] <= 1'b1;
			dirty[tag_way] <= tag_dirty;
		end
	end

	// Tags themselves
	always_ff @(posedge clk) begin
		if (tag_we)
			tag[tag_way] <= adr;
	end

	////////////////////////////////////////
	// Parallel compare
	////////////////////////////////////////

	always_comb begin
		lookup.hit = 1'b0;
		lookup.way = '0;
		for (int i = 0; i < N_WAYS; i++) begin
			if (valid[i] && tag[i] == adr) begin	// At most one way matches
				lookup.hit = 1'b1;
				lookup.way = cache_pkg::way_idx_t'(i);
			end
		end
		lookup.victim_dirty = valid[lru_way] && dirty[lru_way];
		lookup.victim_tag   = tag[lru_way];
	end

endmodule

/* src/wb_pkg.sv */
// Wishbone classic bus types, one byte wide with 8-bit addresses
package wb_pkg;

	////////////////////////////////////////
	// Bus operation
	////////////////////////////////////////

	// Same encoding as the we line
	typedef enum logic {
		WB_READ  = 1'b0,
		WB_WRITE = 1'b1
	} wb_op_t;

	////////////////////////////////////////
	// Master to slave
	////////////////////////////////////////

	typedef struct packed {
		logic       cyc;	// Bus cycle in progress
		logic       stb;	// Valid strobe
		wb_op_t     op;		// Read or write
		logic [7:0] adr;	// Byte address
		logic [7:0] dat;	// Write data
	} wb_req_t;

	////////////////////////////////////////
	// Slave to master
	////////////////////////////////////////

	typedef struct packed {
		logic       ack;	// Single cycle termination
		logic [7:0] dat;	// Read data, valid with ack
	} wb_rsp_t;

endpackage

/* test/cache_assert.sv */
`timescale 1ns/1ps

module cache_assert (
	input logic               clk,
	input logic               rst_n,
	input wb_pkg::wb_req_t    cpu_req,
	input wb_pkg::wb_rsp_t    cpu_rsp,
	input logic               hit,
	input cache_pkg::lookup_t lookup,
	input wb_pkg::wb_req_t    ram_req,
	input wb_pkg::wb_rsp_t    ram_rsp
);

	int unsigned fail_cnt = 0;	// Read by the testbench summary

	////////////////////////////////////////
	// Processor port
	////////////////////////////////////////

	a_cpu_ack_pulse : assert property (@(posedge clk) disable iff (!rst_n)
		cpu_rsp.ack |=> !cpu_rsp.ack)
		else begin $error("cpu ack held longer than one cycle"); fail_cnt++; end

	a_cpu_ack_stb : assert property (@(posedge clk) disable iff (!rst_n)
		cpu_rsp.ack |-> (cpu_req.cyc && cpu_req.stb))
		else begin $error("cpu ack without cyc and stb"); fail_cnt++; end

	a_hit_with_ack : assert property (@(posedge clk) disable iff (!rst_n)
		hit |-> cpu_rsp.ack)
		else begin $error("hit raised without ack"); fail_cnt++; end

	// Strobe rose two samples back, tags matched in lookup
	a_hit_latency : assert property (@(posedge clk) disable iff (!rst_n)
		(lookup.hit && $past(cpu_req.stb) && !$past(cpu_req.stb, 2))
		|=> !cpu_rsp.ack ##1 (cpu_rsp.ack && hit))
		else begin $error("hit not acked two cycles after its strobe"); fail_cnt++; end

	////////////////////////////////////////
	// RAM port
	////////////////////////////////////////

	a_ram_stb_cyc : assert property (@(posedge clk) disable iff (!rst_n)
		ram_req.stb |-> ram_req.cyc)
		else begin $error("ram stb without cyc"); fail_cnt++; end

	a_ram_ack_pulse : assert property (@(posedge clk) disable iff (!rst_n)
		ram_rsp.ack |=> !ram_rsp.ack)
		else begin $error("ram ack held longer than one cycle"); fail_cnt++; end

	a_ram_ack_stb : assert property (@(posedge clk) disable iff (!rst_n)
		ram_rsp.ack |-> (ram_req.cyc && ram_req.stb))
		else begin $error("ram ack without cyc and stb"); fail_cnt++; end

	// Quiet bus right out of reset
	a_reset_quiet : assert property (@(posedge clk)
		$rose(rst_n) |-> (!cpu_rsp.ack && !hit && !ram_req.cyc && !ram_req.stb))
		else begin $error("bus not idle after reset"); fail_cnt++; end

endmodule

bind cache_top cache_assert chk (
	.clk, .rst_n, .cpu_req, .cpu_rsp, .hit, .lookup, .ram_req, .ram_rsp
);

/* test/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

	localparam int N_WAYS  = 4;
	localparam int TIMEOUT = 40;	// Cycles allowed per access
	localparam logic [7:0] LRU_SEQ [7] = '{8'h10, 8'h20, 8'h30, 8'h40, 8'h10, 8'h50, 8'h20};

	logic            clk;
	logic            rst_n;
	wb_pkg::wb_req_t cpu_req;
	wb_pkg::wb_rsp_t cpu_rsp;
	logic            hit;

	logic [7:0]  ref_mem [256];	// Expected memory image
	logic [7:0]  lru_q [$];		// Cached addresses, oldest first
	logic [31:0] rng;
	int          checks;
	int          errors;
	bit          hung;			// Set once an ack never came

	clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) u_clk (.clk, .rst_n);

	cache_top #(.N_WAYS(N_WAYS)) dut (.clk, .rst_n, .cpu_req, .cpu_rsp, .hit);

	////////////////////////////////////////
	// Models
	////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Returns the expected hit and moves adr to the MRU end
	function automatic bit lru_access(input logic [7:0] adr);
		int idx;
		idx = -1;
		foreach (lru_q[i])
			if (lru_q[i] == adr)
				idx = i;
		if (idx >= 0)
			lru_q.delete(idx);
		else if (lru_q.size() == N_WAYS)
			void'(lru_q.pop_front());	// Oldest entry is the victim
		lru_q.push_back(adr);
		return idx >= 0;
	endfunction

	task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	////////////////////////////////////////
	// One Wishbone access
	////////////////////////////////////////

	task automatic access(input string name, input wb_pkg::wb_op_t op,
		input logic [7:0] adr, input logic [7:0] dat);
		int         n;
		bit         exp_hit;
		logic [7:0] exp_dat;
		if (!hung) begin
			exp_hit = lru_access(adr);
			if (op == wb_pkg::WB_WRITE)
				ref_mem[adr] = dat;
			exp_dat = ref_mem[adr];
			@(posedge clk);
			cpu_req <= '{cyc: 1'b1, stb: 1'b1, op: op, adr: adr, dat: dat};
			n = 0;
			@(negedge clk);		// Outputs settled mid cycle
			while (!cpu_rsp.ack && n < TIMEOUT) begin
				@(negedge clk);
				n++;
			end
			if (!cpu_rsp.ack) begin
				hung = 1'b1;
				errors++;
				$display("Ack never came for %s at address %h", name, adr);
			end else begin
				if (op == wb_pkg::WB_READ)
					compare(name, exp_dat, cpu_rsp.dat);
				compare({name, " hit"}, {7'b0, exp_hit}, {7'b0, hit});
			end
			@(posedge clk);
			cpu_req <= '0;	// Strobe low for one cycle between accesses
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		int             n;
		logic [7:0]     adr;
		wb_pkg::wb_op_t op;
		cpu_req = '0;
		checks  = 0;
		errors  = 0;
		hung    = 1'b0;
		rng     = 32'h2e91;
		foreach (ref_mem[i])
			ref_mem[i] = 8'h00;		// RAM clears at reset
		n = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			hung = 1'b1;
			errors++;
			$display("Reset was never released");
		end

		// Unwritten addresses read zero and miss
		for (int i = 0; i < 4; i++)
			access("reset_read", wb_pkg::WB_READ, 8'h80 + 8'(i), 8'h00);

		// Sequence A B C D A E B where E evicts B and keeps A
		foreach (LRU_SEQ[i])
			access("lru_order", wb_pkg::WB_READ, LRU_SEQ[i], 8'h00);

		// 16 addresses over 4 ways forces dirty evictions and refills
		for (int i = 0; i < 300; i++) begin
			rng = lcg_next(rng);
			adr = 8'hc0 + {4'h0, rng[19:16]};
			op  = wb_pkg::wb_op_t'(rng[23]);
			access("random_rw", op, adr, rng[31:24]);
		end

		repeat (3) @(posedge clk);	// Let pending assertions finish
		$display("Checks %0d, errors %0d, assertion failures %0d",
			checks, errors, dut.chk.fail_cnt);
		if (errors == 0 && dut.chk.fail_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* test/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;	// Reset held from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;	// Released on an edge, like the stimulus
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule
